// File: hw/board_ctrl_pkg.sv
// register bus types, register address map, interrupt source indices, watchdog states
package board_ctrl_pkg;

	typedef logic [4:0] csr_addr_t;
	typedef logic [7:0] csr_data_t;

	// one write port shared by every block
	typedef struct packed {
		logic      we;
		csr_addr_t addr;
		csr_data_t wdata;
	} csr_bus_t;

	// ****************************************
	// register map
	// ****************************************
	localparam csr_addr_t ADDR_VERSION       = 5'h00;
	localparam csr_addr_t ADDR_WDT_CTRL      = 5'h04;
	localparam csr_addr_t ADDR_WDT_TIMEOUT   = 5'h05;
	localparam csr_addr_t ADDR_WDT_KICK      = 5'h06;
	localparam csr_addr_t ADDR_PWM_CTRL      = 5'h0c;
	localparam csr_addr_t ADDR_PWM_DUTY      = 5'h0d;
	localparam csr_addr_t ADDR_GPIO_DIR      = 5'h10;
	localparam csr_addr_t ADDR_GPIO_OUT      = 5'h11;
	localparam csr_addr_t ADDR_GPIO_IN       = 5'h12;
	localparam csr_addr_t ADDR_GPIO_IRQ_EN   = 5'h13;
	localparam csr_addr_t ADDR_GPIO_IRQ_STAT = 5'h14;
	localparam csr_addr_t ADDR_INTC_EN       = 5'h1c;
	localparam csr_addr_t ADDR_INTC_STAT     = 5'h1d;

	// ****************************************
	// interrupt sources
	// ****************************************
	localparam int IRQ_RTC     = 0;
	localparam int IRQ_PWR_BTN = 1;
	localparam int IRQ_GPIO    = 2;
	localparam int IRQ_WDT     = 3;
	localparam int NUM_IRQS    = 4;

	typedef enum logic [1:0] {
		IDLE,
		RUNNING,
		EXPIRED
	} wdt_state_t;

endpackage

// File: hw/clock_enables.sv
// fast and slow clock-enable pulse generator
`timescale 1ns/1ps

module clock_enables #(
	parameter int FAST_DIV = 2,
	parameter int SLOW_DIV = 64
) (
	input  logic clk,
	input  logic rst,
	output logic ce_fast,
	output logic ce_slow
);

	localparam int DIVS [2] = '{FAST_DIV, SLOW_DIV};

	logic pulse [2];

	// same divider for both rates, each one free running
	for (genvar i = 0; i < 2; i++) begin : g_div
		localparam int CNT_W = ($clog2(DIVS[i]) > 0) ? $clog2(DIVS[i]) : 1;
		localparam logic [CNT_W-1:0] LAST = CNT_W'(DIVS[i] - 1);

		logic [CNT_W-1:0] cnt;

		always_ff @(posedge clk) begin
			if (rst) begin
				cnt <= '0;
				pulse[i] <= 1'b0;
			end else begin
				pulse[i] <= (cnt == LAST);
				cnt <= (cnt == LAST) ? '0 : cnt + 1'b1;
			end
		end
	end

	assign ce_fast = pulse[0];
	assign ce_slow = pulse[1];

endmodule

// File: hw/input_sync.sv
// two-flop input synchronizer with level and edge pulse outputs
`timescale 1ns/1ps

module input_sync #(
	parameter int WIDTH = 1
) (
	input  logic             clk,
	input  logic             rst,
	input  logic [WIDTH-1:0] in,
	output logic [WIDTH-1:0] level,
	output logic [WIDTH-1:0] rise,
	output logic [WIDTH-1:0] fall
);

	logic [WIDTH-1:0] meta;
	logic [WIDTH-1:0] sync;
	logic [WIDTH-1:0] prev; // history stage for the edge compare

	always_ff @(posedge clk) begin
		if (rst) begin
			meta <= '0;
			sync <= '0;
			prev <= '0;
		end else begin
			meta <= in;
			sync <= meta;
			prev <= sync;
		end
	end

	assign level = sync;
	assign rise = sync & ~prev;
	assign fall = ~sync & prev;

endmodule

// File: hw/gpio_bank.sv
// GPIO direction, output, input and edge interrupt registers
`timescale 1ns/1ps

module gpio_bank import board_ctrl_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  csr_bus_t   csr,
	output csr_data_t  rd_data,
	input  logic [7:0] pin_level,
	input  logic [7:0] pin_rise,
	output logic [7:0] gpio_out,
	output logic [7:0] gpio_oe,
	output logic       irq
);

	csr_data_t dir_q;
	csr_data_t out_q;
	csr_data_t irq_en_q;
	csr_data_t irq_stat_q;

	logic [7:0] new_events;
	csr_data_t stat_clr;

	// only input pins with their enable set can raise status
	assign new_events = pin_rise & ~dir_q & irq_en_q;
	assign stat_clr = (csr.we && csr.addr == ADDR_GPIO_IRQ_STAT) ? csr.wdata : '0;

	// ****************************************
	// registers
	// ****************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			dir_q <= '0;
			out_q <= '0;
			irq_en_q <= '0;
			irq_stat_q <= '0;
			irq <= 1'b0;
		end else begin
			if (csr.we) begin
				case (csr.addr)
					ADDR_GPIO_DIR: dir_q <= csr.wdata;
					ADDR_GPIO_OUT: out_q <= csr.wdata;
					ADDR_GPIO_IRQ_EN: irq_en_q <= csr.wdata;
					default: ;
				endcase
			end
			irq_stat_q <= (irq_stat_q & ~stat_clr) | new_events; // new edge wins over clear
			irq <= |(new_events & ~irq_stat_q);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_data <= '0;
		end else begin
			case (csr.addr)
				ADDR_GPIO_DIR: rd_data <= dir_q;
				ADDR_GPIO_OUT: rd_data <= out_q;
				ADDR_GPIO_IN: rd_data <= pin_level;
				ADDR_GPIO_IRQ_EN: rd_data <= irq_en_q;
				ADDR_GPIO_IRQ_STAT: rd_data <= irq_stat_q;
				default: rd_data <= '0;
			endcase
		end
	end

	assign gpio_out = out_q;
	assign gpio_oe = dir_q; // a direction bit of 1 drives the pin

endmodule

// File: hw/intc.sv
// interrupt controller with pending and enable registers and a level irq
`timescale 1ns/1ps

module intc import board_ctrl_pkg::*; #(
	parameter int NUM_IRQS = 4
) (
	input  logic                clk,
	input  logic                rst,
	input  csr_bus_t            csr,
	output csr_data_t           rd_data,
	input  logic [NUM_IRQS-1:0] sources,
	output logic                irq
);

	logic [NUM_IRQS-1:0] pending_q;
	logic [NUM_IRQS-1:0] enable_q;
	logic [NUM_IRQS-1:0] clr;

	assign clr = (csr.we && csr.addr == ADDR_INTC_STAT) ? csr.wdata[NUM_IRQS-1:0] : '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			pending_q <= '0;
			enable_q <= '0;
			irq <= 1'b0;
		end else begin
			if (csr.we && csr.addr == ADDR_INTC_EN)
				enable_q <= csr.wdata[NUM_IRQS-1:0];
			// a source pulse in the clearing cycle stays pending
			pending_q <= (pending_q & ~clr) | sources;
			irq <= |(pending_q & enable_q);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_data <= '0;
		end else begin
			case (csr.addr)
				ADDR_INTC_EN: rd_data <= csr_data_t'(enable_q);
				ADDR_INTC_STAT: rd_data <= csr_data_t'(pending_q);
				default: rd_data <= '0;
			endcase
		end
	end

endmodule

// File: hw/watchdog.sv
// watchdog with control, timeout and kick registers and expiry strobes
`timescale 1ns/1ps

module watchdog import board_ctrl_pkg::*; #(
	parameter csr_data_t WDT_DEFAULT_TIMEOUT = 8'd8
) (
	input  logic      clk,
	input  logic      rst,
	input  logic      ce_slow,
	input  csr_bus_t  csr,
	output csr_data_t rd_data,
	output logic      expire,
	output logic      cpu_reset
);

	wdt_state_t state;
	csr_data_t timeout_q;
	csr_data_t count;
	logic rst_mode;

	logic wr_ctrl;
	logic wr_timeout;
	logic reload;
	csr_data_t reload_val;

	assign wr_ctrl = csr.we && csr.addr == ADDR_WDT_CTRL;
	assign wr_timeout = csr.we && csr.addr == ADDR_WDT_TIMEOUT;
	assign reload = wr_timeout || (csr.we && csr.addr == ADDR_WDT_KICK);
	assign reload_val = wr_timeout ? csr.wdata : timeout_q; // new timeout takes effect at once

	// ****************************************
	// state machine and counter
	// ****************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			timeout_q <= WDT_DEFAULT_TIMEOUT;
			count <= '0;
			rst_mode <= 1'b0;
			expire <= 1'b0;
			cpu_reset <= 1'b0;
		end else begin
			expire <= 1'b0;
			cpu_reset <= 1'b0;
			if (wr_timeout)
				timeout_q <= csr.wdata;
			if (wr_ctrl)
				rst_mode <= csr.wdata[1];

			case (state)
				IDLE: if (wr_ctrl && csr.wdata[0]) begin
					state <= RUNNING;
					count <= reload_val;
				end
				RUNNING: if (wr_ctrl && !csr.wdata[0]) begin
					state <= IDLE;
				end else if (reload) begin
					count <= reload_val;
				end else if (ce_slow) begin
					if (count <= 8'd1) begin // this tick takes the count to zero
						count <= '0;
						state <= EXPIRED;
						expire <= 1'b1;
						cpu_reset <= rst_mode;
					end else begin
						count <= count - 1'b1;
					end
				end
				EXPIRED: if (wr_ctrl && !csr.wdata[0]) begin
					state <= IDLE;
				end else if (csr.we && csr.addr == ADDR_WDT_KICK) begin
					state <= RUNNING;
					count <= timeout_q;
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_data <= '0;
		end else begin
			case (csr.addr)
				ADDR_WDT_CTRL: rd_data <= {state == EXPIRED, 5'b0, rst_mode, state != IDLE};
				ADDR_WDT_TIMEOUT: rd_data <= timeout_q;
				default: rd_data <= '0;
			endcase
		end
	end

endmodule

// File: hw/backlight_pwm.sv
// backlight PWM with enable and duty registers
`timescale 1ns/1ps

module backlight_pwm import board_ctrl_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      ce_fast,
	input  csr_bus_t  csr,
	output csr_data_t rd_data,
	output logic      pwm_out
);

	logic enable_q;
	csr_data_t duty_q;
	csr_data_t cnt; // one full period is 256 fast ticks

	always_ff @(posedge clk) begin
		if (rst) begin
			enable_q <= 1'b0;
			duty_q <= '0;
		end else if (csr.we) begin
			case (csr.addr)
				ADDR_PWM_CTRL: enable_q <= csr.wdata[0];
				ADDR_PWM_DUTY: duty_q <= csr.wdata;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= '0;
			pwm_out <= 1'b0;
		end else begin
			if (ce_fast)
				cnt <= cnt + 1'b1;
			pwm_out <= enable_q && (cnt < duty_q);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_data <= '0;
		end else begin
			case (csr.addr)
				ADDR_PWM_CTRL: rd_data <= {7'b0, enable_q};
				ADDR_PWM_DUTY: rd_data <= duty_q;
				default: rd_data <= '0;
			endcase
		end
	end

endmodule

// File: hw/board_ctrl_top.sv
// board-control top level with version register and read data merge
`timescale 1ns/1ps

module board_ctrl_top import board_ctrl_pkg::*; #(
	parameter int        FAST_DIV = 2,
	parameter int        SLOW_DIV = 64,
	parameter csr_data_t VERSION = 8'h01,
	parameter csr_data_t WDT_DEFAULT_TIMEOUT = 8'd8
) (
	input  logic       clk,
	input  logic       rst,
	input  csr_bus_t   csr,
	output csr_data_t  csr_rd,
	input  logic [7:0] gpio_in,
	output logic [7:0] gpio_out,
	output logic [7:0] gpio_oe,
	input  logic       rtc_int,
	input  logic       pwr_btn,
	output logic       irq,
	output logic       cpu_reset,
	output logic       pwm_out
);

	logic ce_fast;
	logic ce_slow;
	logic [1:0] ev_rise;
	logic [1:0] ev_fall;
	logic [7:0] pin_level;
	logic [7:0] pin_rise;
	logic gpio_irq;
	logic wdt_expire;
	logic [NUM_IRQS-1:0] irq_src;

	csr_data_t rd_version;
	csr_data_t rd_gpio;
	csr_data_t rd_intc;
	csr_data_t rd_wdt;
	csr_data_t rd_pwm;

	clock_enables #(.FAST_DIV(FAST_DIV), .SLOW_DIV(SLOW_DIV)) clock_enables_i (
		.clk(clk), .rst(rst), .ce_fast(ce_fast), .ce_slow(ce_slow)
	);

	// bit 0 is rtc_int, which is active low, bit 1 the power button
	input_sync #(.WIDTH(2)) event_sync_i (
		.clk(clk), .rst(rst), .in({pwr_btn, rtc_int}),
		.level(), .rise(ev_rise), .fall(ev_fall)
	);

	input_sync #(.WIDTH(8)) gpio_sync_i (
		.clk(clk), .rst(rst), .in(gpio_in),
		.level(pin_level), .rise(pin_rise), .fall()
	);

	gpio_bank gpio_bank_i (
		.clk(clk), .rst(rst), .csr(csr), .rd_data(rd_gpio),
		.pin_level(pin_level), .pin_rise(pin_rise),
		.gpio_out(gpio_out), .gpio_oe(gpio_oe), .irq(gpio_irq)
	);

	assign irq_src[IRQ_RTC] = ev_fall[0];
	assign irq_src[IRQ_PWR_BTN] = ev_rise[1];
	assign irq_src[IRQ_GPIO] = gpio_irq;
	assign irq_src[IRQ_WDT] = wdt_expire;

	intc #(.NUM_IRQS(NUM_IRQS)) intc_i (
		.clk(clk), .rst(rst), .csr(csr), .rd_data(rd_intc),
		.sources(irq_src), .irq(irq)
	);

	watchdog #(.WDT_DEFAULT_TIMEOUT(WDT_DEFAULT_TIMEOUT)) watchdog_i (
		.clk(clk), .rst(rst), .ce_slow(ce_slow), .csr(csr), .rd_data(rd_wdt),
		.expire(wdt_expire), .cpu_reset(cpu_reset)
	);

	backlight_pwm backlight_pwm_i (
		.clk(clk), .rst(rst), .ce_fast(ce_fast), .csr(csr), .rd_data(rd_pwm),
		.pwm_out(pwm_out)
	);

	// ****************************************
	// version register and read merge
	// ****************************************
	always_ff @(posedge clk) begin
		if (rst)
			rd_version <= '0;
		else
			rd_version <= (csr.addr == ADDR_VERSION) ? VERSION : '0;
	end

	// every block drives zero unless its own address is selected
	assign csr_rd = rd_version | rd_gpio | rd_intc | rd_wdt | rd_pwm;

endmodule

// File: tests/board_ctrl_tb.sv
// board-control testbench with clock, reset, trace player, checks and reporting
`timescale 1ns/1ps

module board_ctrl_tb import board_ctrl_pkg::*; ();

	localparam csr_data_t VERSION = 8'h21;
	localparam int PWM_WINDOW = 512;
	localparam string TRACE_PATH = "tests/board_ctrl_trace.txt";

	logic clk;
	logic rst;
	csr_bus_t csr;
	csr_data_t csr_rd;
	logic [7:0] gpio_in;
	logic [7:0] gpio_out;
	logic [7:0] gpio_oe;
	logic rtc_int;
	logic pwr_btn;
	logic irq;
	logic cpu_reset;
	logic pwm_out;

	int errors = 0;
	int checks = 0;
	int tests = 0;
	int test_errors = 0;
	int reset_pulses = 0;
	int budget_cycles = 0;
	logic [8*32-1:0] test_name;

	board_ctrl_top #(
		.FAST_DIV(2), .SLOW_DIV(64), .VERSION(VERSION), .WDT_DEFAULT_TIMEOUT(8'd8)
	) dut_i (
		.clk(clk), .rst(rst), .csr(csr), .csr_rd(csr_rd),
		.gpio_in(gpio_in), .gpio_out(gpio_out), .gpio_oe(gpio_oe),
		.rtc_int(rtc_int), .pwr_btn(pwr_btn),
		.irq(irq), .cpu_reset(cpu_reset), .pwm_out(pwm_out)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk)
		if (cpu_reset)
			reset_pulses++; // counted on the edge that ends the pulse

	// ****************************************
	// checks and bus access
	// ****************************************
	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		checks++;
		if (actual !== expected) begin
			errors++;
			test_errors++;
			$display("Mismatch at %0t ns: %0s is %0h, expected %0h", $time, what, actual,
				expected);
		end
	endtask

	task automatic bus_write(input csr_addr_t addr, input csr_data_t data);
		csr.we = 1'b1;
		csr.addr = addr;
		csr.wdata = data;
		@(negedge clk);
		csr.we = 1'b0;
	endtask

	// read data shows up one cycle after the address
	task automatic bus_read(input csr_addr_t addr, input csr_data_t expected);
		csr.we = 1'b0;
		csr.addr = addr;
		@(negedge clk);
		check(csr_rd, expected, $sformatf("read of address %02h", addr));
	endtask

	task automatic measure_pwm(input int expected);
		int high;
		high = 0;
		repeat (PWM_WINDOW) begin
			@(negedge clk);
			if (pwm_out)
				high++;
		end
		check(high, expected, "pwm high cycles");
	endtask

	// each kick ends its interval, so the expiry window opens at the last kick
	task automatic kick_watchdog(input int count, input int interval);
		repeat (count) begin
			repeat (interval - 1) @(negedge clk);
			bus_write(ADDR_WDT_KICK, 8'h00);
		end
	endtask

	task automatic await_reset(input int limit);
		int i;
		logic seen;
		seen = 1'b0;
		for (i = 0; i < limit && !seen; i++) begin
			@(negedge clk);
			seen = cpu_reset;
		end
		check(seen, 1'b1, "cpu_reset pulse before the limit");
	endtask

	task automatic report_test();
		if (tests > 0) begin
			if (test_errors == 0)
				$display("test %0s: ok", test_name);
			else
				$display("test %0s: %0d errors", test_name, test_errors);
		end
	endtask

	// cycles the trace will take, so the timeout scales with the tests
	task automatic sum_trace_cycles(input int fd, output int cycles);
		logic [8*80-1:0] line;
		logic [8*16-1:0] cmd;
		int n;
		int a;
		int b;
		cycles = 0;
		while ($fgets(line, fd) != 0) begin
			cmd = '0;
			a = 0;
			b = 0;
			n = $sscanf(line, "%s %d %d", cmd, a, b);
			case (cmd)
				"wait", "await_reset": cycles += a;
				"kicks": cycles += a * b;
				"measure_pwm": cycles += PWM_WINDOW;
				default: cycles += 2;
			endcase
		end
	endtask

	// ****************************************
	// trace player
	// ****************************************
	initial begin
		int fd;
		int n;
		int da;
		int db;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [8*80-1:0] line;
		logic [8*16-1:0] cmd;

		rst = 1'b1;
		csr = '0;
		gpio_in = '0;
		rtc_int = 1'b1; // rtc_int is active low
		pwr_btn = 1'b0;
		fd = $fopen(TRACE_PATH, "r");
		if (fd == 0) begin
			$display("Could not open the trace file %0s", TRACE_PATH);
			errors++;
		end else begin
			sum_trace_cycles(fd, n);
			$fclose(fd);
			budget_cycles = 2 * n + 300;
			fd = $fopen(TRACE_PATH, "r");
			repeat (8) @(posedge clk);
			@(negedge clk);
			rst = 1'b0;
			while ($fgets(line, fd) != 0) begin
				cmd = '0;
				n = $sscanf(line, "%s %h %h %h", cmd, a, b, c);
				n = $sscanf(line, "%s %d %d", cmd, da, db);
				case (cmd)
					"test": begin
						report_test();
						n = $sscanf(line, "%s %s", cmd, test_name);
						tests++;
						test_errors = 0;
					end
					"write": bus_write(a[4:0], b[7:0]);
					"read": bus_read(a[4:0], b[7:0]);
					"pins": begin
						gpio_in = a[7:0];
						rtc_int = b[0];
						pwr_btn = c[0];
					end
					"wait": repeat (da) @(negedge clk);
					"expect_irq": check(irq, a, "irq level");
					"expect_gpio": begin
						check(gpio_oe, a, "gpio_oe");
						check(gpio_out, b, "gpio_out");
					end
					"measure_pwm": measure_pwm(da);
					"kicks": kick_watchdog(da, db);
					"await_reset": await_reset(da);
					"reset_count": check(reset_pulses, da, "cpu_reset pulse count");
					"#", 0: ;
					default: begin
						errors++;
						$display("Unknown command in the trace: %0s", cmd);
					end
				endcase
			end
			$fclose(fd);
			report_test();
		end
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	initial begin
		wait (budget_cycles > 0);
		repeat (budget_cycles) @(posedge clk);
		$display("The run hung and was stopped after %0d cycles", budget_cycles);
		$display("Test failed");
		$finish;
	end

endmodule

// File: tests/board_ctrl_trace.txt
# columns: command, then hex address and data, or decimal cycle counts
# pins takes gpio_in in hex, then rtc_int and pwr_btn
test reset_version
expect_irq 0
reset_count 0
expect_gpio 00 00
read 00 21
measure_pwm 0
test gpio
write 10 0f
write 11 a5
expect_gpio 0f a5
pins 1a 1 0
wait 5
read 12 1a
write 13 40
pins 5a 1 0
wait 5
read 14 40
write 14 40
read 14 00
test intc
write 1d 0f
write 1c 05
pins 5a 0 0
wait 5
read 1d 01
expect_irq 1
pins 5a 0 1
wait 5
read 1d 03
expect_irq 1
write 1d 01
wait 2
expect_irq 0
pins 5a 1 0
write 1d 0f
read 1d 00
test wdt_kick
write 05 04
write 04 03
kicks 8 128
reset_count 0
test wdt_expire
await_reset 330
wait 2
reset_count 1
read 1d 08
read 04 83
test pwm
write 0d 40
write 0c 01
wait 4
measure_pwm 128
write 0d 00
wait 4
measure_pwm 0
write 0d 40
write 0c 00
wait 4
measure_pwm 0

// File: sim.f
hw/board_ctrl_pkg.sv
hw/clock_enables.sv
hw/input_sync.sv
hw/gpio_bank.sv
hw/intc.sv
hw/watchdog.sv
hw/backlight_pwm.sv
hw/board_ctrl_top.sv
tests/board_ctrl_tb.sv
